/* ls_local_top.f */
+incdir+include
hdl/ls_local_pkg.sv
hdl/ls_request_decode.sv
hdl/fp_dbram.sv
hdl/local_data_mem.sv
hdl/load_formatter.sv
hdl/ls_local_top.sv
tests/tb_ls_local.sv

/* Bender.yml */
package:
  name: ls_local

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/ls_local_pkg.sv
      - hdl/ls_request_decode.sv
      - hdl/fp_dbram.sv
      - hdl/local_data_mem.sv
      - hdl/load_formatter.sv
      - hdl/ls_local_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_ls_local.sv

/* tests/tb_ls_local.sv */
/*
 * Testbench for the local load/store path: directed table,
 * aligned random mix, byte-array reference memory and watchdog.
 */

`timescale 1ns/10ps

`include "ls_local_defs.svh"

module tb_ls_local;

    import ls_local_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_PREFILL = 8;
    localparam int NUM_RANDOM = 300;
    localparam logic [31:0] RAND_BASE = 32'h0000_0200;

    // One directed step.
    typedef struct packed {
        ls_op_e      op;
        logic [31:0] addr;
        logic [63:0] data;
        logic        is_load;
    } tb_entry_t;

    logic clk;
    logic rst;
    logic new_request;
    ls_request_t request;
    logic data_valid;
    logic [`LS_FLEN-1:0] load_data;

    tb_entry_t stim_table[$];
    logic [7:0] ref_mem [0:1023];

    // Expectation for the cycle after a strobe.
    logic pend_valid;
    logic [63:0] pend_data;
    ls_op_e pend_op;

    int seed = 85;
    int valid_errors;
    int load_errors;
    int num_checks;

    ls_local_top uut (
        .clk         (clk),
        .rst         (rst),
        .new_request (new_request),
        .request     (request),
        .data_valid  (data_valid),
        .load_data   (load_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic add_entry(input ls_op_e op, input logic [31:0] addr,
                             input logic [63:0] data, input logic is_load);
        tb_entry_t e;
        e.op = op;
        e.addr = addr;
        e.data = data;
        e.is_load = is_load;
        stim_table.push_back(e);
    endtask

    // Directed steps, applied back to back.
    task automatic build_table();
        // Word stores and loads, neighbour word kept.
        add_entry(LS_SW,  32'h40, 64'h8123_4567, 1'b0);
        add_entry(LS_SW,  32'h44, 64'h1234_5678, 1'b0);
        add_entry(LS_LW,  32'h40, 64'h0, 1'b1);
        add_entry(LS_LW,  32'h44, 64'h0, 1'b1);
        add_entry(LS_SW,  32'h44, 64'hfedc_ba98, 1'b0);
        add_entry(LS_LW,  32'h40, 64'h0, 1'b1);
        add_entry(LS_LW,  32'h44, 64'h0, 1'b1);
        // Byte lanes.
        add_entry(LS_SW,  32'h48, 64'h0000_0000, 1'b0);
        add_entry(LS_SB,  32'h48, 64'h80, 1'b0);
        add_entry(LS_SB,  32'h49, 64'h7f, 1'b0);
        add_entry(LS_SB,  32'h4a, 64'hc3, 1'b0);
        add_entry(LS_LB,  32'h48, 64'h0, 1'b1);
        add_entry(LS_LBU, 32'h49, 64'h0, 1'b1);
        add_entry(LS_SB,  32'h4b, 64'h91, 1'b0);
        add_entry(LS_LB,  32'h4a, 64'h0, 1'b1);
        add_entry(LS_LBU, 32'h4b, 64'h0, 1'b1);
        add_entry(LS_LW,  32'h48, 64'h0, 1'b1);
        // Half lanes.
        add_entry(LS_SW,  32'h4c, 64'haaaa_5555, 1'b0);
        add_entry(LS_SH,  32'h4c, 64'h8001, 1'b0);
        add_entry(LS_LH,  32'h4c, 64'h0, 1'b1);
        add_entry(LS_LHU, 32'h4e, 64'h0, 1'b1);
        add_entry(LS_SH,  32'h4e, 64'h7ffe, 1'b0);
        add_entry(LS_LH,  32'h4e, 64'h0, 1'b1);
        add_entry(LS_LHU, 32'h4c, 64'h0, 1'b1);
        add_entry(LS_LW,  32'h4c, 64'h0, 1'b1);
        // Double and its halves.
        add_entry(LS_FSD, 32'h50, 64'h0123_4567_89ab_cdef, 1'b0);
        add_entry(LS_FLD, 32'h50, 64'h0, 1'b1);
        add_entry(LS_LW,  32'h50, 64'h0, 1'b1);
        add_entry(LS_LW,  32'h54, 64'h0, 1'b1);
        // Singles, NaN-boxed on load.
        add_entry(LS_SW,  32'h58, 64'h5555_aaaa, 1'b0);
        add_entry(LS_SW,  32'h5c, 64'h1357_9bdf, 1'b0);
        add_entry(LS_FSW, 32'h58, 64'hdead_beef_3f80_0000, 1'b0);
        add_entry(LS_FLW, 32'h58, 64'h0, 1'b1);
        add_entry(LS_LW,  32'h5c, 64'h0, 1'b1);
        add_entry(LS_FSW, 32'h5c, 64'h4049_0fdb, 1'b0);
        add_entry(LS_FLW, 32'h5c, 64'h0, 1'b1);
        add_entry(LS_LW,  32'h58, 64'h0, 1'b1);
        add_entry(LS_FLD, 32'h58, 64'h0, 1'b1);
    endtask

    function automatic logic op_is_load(input ls_op_e op);
        return op inside {LS_LB, LS_LH, LS_LW, LS_LBU, LS_LHU, LS_FLW, LS_FLD};
    endfunction

    // Natural alignment for the access size.
    function automatic logic [31:0] align_addr(input ls_op_e op, input logic [31:0] a);
        case (op)
            LS_LB, LS_LBU, LS_SB: return a;
            LS_LH, LS_LHU, LS_SH: return {a[31:1], 1'b0};
            LS_FLD, LS_FSD: return {a[31:3], 3'b000};
            default: return {a[31:2], 2'b00};
        endcase
    endfunction

    // Little-endian words from the reference bytes.
    function automatic logic [31:0] ref_word(input logic [31:0] a);
        logic [9:0] w;
        w = {a[9:2], 2'b00};
        return {ref_mem[w + 3], ref_mem[w + 2], ref_mem[w + 1], ref_mem[w]};
    endfunction

    function automatic logic [63:0] expected_load(input ls_op_e op, input logic [31:0] a);
        logic [31:0] word;
        logic [7:0] b;
        logic [15:0] h;
        word = ref_word(a);
        b = ref_mem[a[9:0]];
        h = {ref_mem[{a[9:1], 1'b1}], ref_mem[{a[9:1], 1'b0}]};
        case (op)
            LS_LB:  return {{56{b[7]}}, b};
            LS_LBU: return {56'b0, b};
            LS_LH:  return {{48{h[15]}}, h};
            LS_LHU: return {48'b0, h};
            LS_LW:  return {{32{word[31]}}, word};
            LS_FLW: return {32'hffff_ffff, word};
            LS_FLD: return {ref_word({a[31:3], 3'b100}), ref_word({a[31:3], 3'b000})};
            default: return 64'h0;
        endcase
    endfunction

    task automatic store_ref(input ls_op_e op, input logic [31:0] a, input logic [63:0] d);
        logic [9:0] b;
        b = a[9:0];
        case (op)
            LS_SB: ref_mem[b] = d[7:0];
            LS_SH: begin
                ref_mem[b] = d[7:0];
                ref_mem[b + 1] = d[15:8];
            end
            LS_SW, LS_FSW: begin
                for (int i = 0; i < 4; i++)
                    ref_mem[b + i] = d[i*8 +: 8];
            end
            LS_FSD: begin
                for (int i = 0; i < 8; i++)
                    ref_mem[b + i] = d[i*8 +: 8];
            end
            default: ;
        endcase
    endtask

    task automatic check_valid(input logic actual, input logic expected);
        num_checks++;
        if (actual !== expected) begin
            valid_errors++;
            $display("ERR data_valid: expected %h, actual %h at %0t", expected, actual, $time);
        end
    endtask

    task automatic check_load(input logic [`LS_FLEN-1:0] actual,
                              input logic [`LS_FLEN-1:0] expected, input ls_op_e op);
        num_checks++;
        if (actual !== expected) begin
            load_errors++;
            $display("ERR load_data (%s): expected %h, actual %h at %0t",
                     op.name(), expected, actual, $time);
        end
    endtask

    // One cycle: drive, then check the result of the previous strobe mid-cycle.
    task automatic apply_step(input logic strobe, input ls_op_e op, input logic [31:0] addr,
                              input logic [63:0] data, input logic is_load);
        @(posedge clk);
        #2;
        new_request = strobe;
        request.op = op;
        request.addr = addr;
        request.data = data[31:0];
        request.fp_data = data;
        @(negedge clk);
        check_valid(data_valid, pend_valid);
        if (pend_valid)
            check_load(load_data, pend_data, pend_op);
        pend_valid = strobe & is_load;
        if (strobe && is_load) begin
            pend_data = expected_load(op, addr);
            pend_op = op;
        end
        if (strobe && !is_load)
            store_ref(op, addr, data);
    endtask

    task automatic idle_step();
        apply_step(1'b0, LS_LW, 32'h0, 64'h0, 1'b0);
    endtask

    initial begin
        int limit;
        ls_op_e op;
        logic [31:0] r;
        logic [31:0] a;
        logic [63:0] d;

        clk = 1'b0;
        rst = 1'b1;
        new_request = 1'b0;
        request = '0;
        pend_valid = 1'b0;
        pend_data = '0;
        pend_op = LS_LW;
        valid_errors = 0;
        load_errors = 0;
        num_checks = 0;
        build_table();

        limit = (stim_table.size() + NUM_PREFILL + NUM_RANDOM) * 4 * CLK_PERIOD
                + RESET_CYCLES * CLK_PERIOD;
        fork
            begin
                #(limit);
                $display("Watchdog expired: the run did not finish in time.");
                $display("test failed");
                $finish;
            end
        join_none

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        // Quiet after reset.
        repeat (3) idle_step();

        foreach (stim_table[i])
            apply_step(1'b1, stim_table[i].op, stim_table[i].addr,
                       stim_table[i].data, stim_table[i].is_load);
        repeat (2) idle_step();

        // Random window starts fully written.
        for (int i = 0; i < NUM_PREFILL; i++) begin
            d = {$random(seed), $random(seed)};
            apply_step(1'b1, LS_FSD, RAND_BASE + i * 8, d, 1'b0);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = $unsigned($random(seed)) % 12;
            op = ls_op_e'(r[3:0]);
            r = $unsigned($random(seed)) % 64;
            a = align_addr(op, RAND_BASE + r);
            d = {$random(seed), $random(seed)};
            apply_step(1'b1, op, a, d, op_is_load(op));
        end
        repeat (2) idle_step();

        $display("Checks %0d, data_valid errors %0d, load_data errors %0d",
                 num_checks, valid_errors, load_errors);
        if (valid_errors == 0 && load_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* hdl/ls_local_top.sv */
/*
 * Local data memory path top.
 * Decoder, adapter, RAM and load formatter.
 */

`timescale 1ns/10ps

`include "ls_local_defs.svh"

module ls_local_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      new_request,
    input  ls_local_pkg::ls_request_t request,
    output logic                      data_valid,
    output logic [`LS_FLEN-1:0]       load_data
);

    import ls_local_pkg::*;

    data_access_shared_inputs_t ls_inputs;
    local_mem_port_t mem_port;
    logic [`LS_FLEN-1:0] mem_rdata;
    logic [`LS_FLEN-1:0] sub_unit_data;

    // Combinational decode.
    ls_request_decode decode_i (
        .request   (request),
        .ls_inputs (ls_inputs)
    );

    // Sub-unit adapter.
    fp_dbram dbram_i (
        .clk           (clk),
        .rst           (rst),
        .new_request   (new_request),
        .ls_inputs     (ls_inputs),
        .data_valid    (data_valid),
        .sub_unit_data (sub_unit_data),
        .mem_port      (mem_port),
        .mem_rdata     (mem_rdata)
    );

    // Local RAM.
    local_data_mem mem_i (
        .clk      (clk),
        .mem_port (mem_port),
        .rdata    (mem_rdata)
    );

    // Result formatting.
    load_formatter fmt_i (
        .clk           (clk),
        .rst           (rst),
        .new_request   (new_request),
        .ls_inputs     (ls_inputs),
        .data_valid    (data_valid),
        .sub_unit_data (sub_unit_data),
        .load_data     (load_data)
    );

endmodule

/* hdl/load_formatter.sv */
/*
 * Load result formatter.
 * Lane select, sign/zero extension and single NaN-boxing.
 */

`timescale 1ns/10ps

`include "ls_local_defs.svh"

module load_formatter (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     new_request,
    input  ls_local_pkg::data_access_shared_inputs_t ls_inputs,
    input  logic                                     data_valid,
    input  logic [`LS_FLEN-1:0]                      sub_unit_data,
    output logic [`LS_FLEN-1:0]                      load_data
);

    import ls_local_pkg::*;

    load_info_t info;
    ls_op_e op_in;
    logic [31:0] word;
    logic [7:0] byte_val;
    logic [15:0] half_val;
    logic [`LS_FLEN-1:0] formatted;

    // Load opcode carried in the data field of a load.
    assign op_in = ls_op_e'(ls_inputs.data_in[3:0]);

    // Pending load capture.
    always_ff @(posedge clk) begin
        if (rst) begin
            info <= '0;
        end else if (new_request && ls_inputs.load) begin
            info.op <= op_in;
            info.offset <= ls_inputs.addr[2:0];
        end
    end

    // Offset 0 word sits in the upper half.
    assign word = info.offset[2] ? sub_unit_data[31:0] : sub_unit_data[63:32];
    assign byte_val = word[info.offset[1:0]*8 +: 8];
    assign half_val = info.offset[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (info.op)
            LS_LB:   formatted = {{56{byte_val[7]}}, byte_val};
            LS_LBU:  formatted = {56'b0, byte_val};
            LS_LH:   formatted = {{48{half_val[15]}}, half_val};
            LS_LHU:  formatted = {48'b0, half_val};
            LS_LW:   formatted = {{32{word[31]}}, word};
            LS_FLW:  formatted = {32'hffff_ffff, word};  // NaN-box.
            LS_FLD:  formatted = sub_unit_data;
            default: formatted = '0;
        endcase
    end

    // Quiet between pulses.
    assign load_data = data_valid ? formatted : '0;

endmodule

/* hdl/local_data_mem.sv */
/*
 * 64-bit byte-enabled local data RAM, one-cycle read.
 */

`timescale 1ns/10ps

`include "ls_local_defs.svh"

module local_data_mem (
    input  logic                          clk,
    input  ls_local_pkg::local_mem_port_t mem_port,
    output logic [`LS_FLEN-1:0]           rdata
);

    import ls_local_pkg::*;

    localparam int DEPTH = 2 ** `LS_MEM_DEPTH_LOG2;
    localparam int NUM_BYTES = `LS_FLEN / 8;

    logic [`LS_FLEN-1:0] mem [DEPTH];
    logic [NUM_BYTES-1:0] byte_we;

    // Row byte strobes.
    // Word enables land in the upper half for word_sel 0.
    always_comb begin
        byte_we = '0;
        if (mem_port.en) begin
            if (mem_port.we.both)
                byte_we = '1;
            else if (mem_port.we.word && mem_port.word_sel)
                byte_we = {4'b0000, mem_port.be};
            else if (mem_port.we.word)
                byte_we = {mem_port.be, 4'b0000};
        end
    end

    always_ff @(posedge clk) begin
        // Read first; write lands after.
        if (mem_port.en)
            rdata <= mem[mem_port.addr];
        for (int i = 0; i < NUM_BYTES; i++) begin
            if (byte_we[i])
                mem[mem_port.addr][i*8 +: 8] <= mem_port.data_in[i*8 +: 8];
        end
    end

endmodule

/* hdl/fp_dbram.sv */
/*
 * Float-capable local RAM sub-unit adapter.
 * Maps access signals onto the RAM port and fixes double word order.
 */

`timescale 1ns/10ps

`include "ls_local_defs.svh"

module fp_dbram (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     new_request,
    input  ls_local_pkg::data_access_shared_inputs_t ls_inputs,
    output logic                                     data_valid,
    output logic [`LS_FLEN-1:0]                      sub_unit_data,
    output ls_local_pkg::local_mem_port_t            mem_port,
    input  logic [`LS_FLEN-1:0]                      mem_rdata
);

    import ls_local_pkg::*;

    logic is_double;
    logic [31:0] word_data;
    logic [`LS_FLEN-1:0] swapped_fp_data;
    logic double_read;

    assign is_double = ls_inputs.is_float & ~ls_inputs.is_single;

    // Double keeps its low word at offset 0, which is the row's upper half.
    assign swapped_fp_data = {ls_inputs.fp_data_in[31:0], ls_inputs.fp_data_in[63:32]};

    // Integer or single word to store.
    assign word_data = ls_inputs.is_float ? ls_inputs.fp_data_in[31:0] : ls_inputs.data_in;

    always_comb begin
        mem_port.addr = ls_inputs.addr[3 +: `LS_MEM_DEPTH_LOG2];
        mem_port.en = new_request;
        mem_port.word_sel = ls_inputs.addr[2];
        mem_port.be = ls_inputs.be;
        mem_port.we.both = ls_inputs.we & is_double;
        mem_port.we.word = ls_inputs.we & ~is_double;

        // Offset 0 lives in bits 63:32.
        if (is_double)
            mem_port.data_in = swapped_fp_data;
        else if (ls_inputs.addr[2])
            mem_port.data_in = {32'b0, word_data};
        else
            mem_port.data_in = {word_data, 32'b0};
    end

    // Always ready.
    // Valid one cycle after a load strobe.
    always_ff @(posedge clk) begin
        if (rst) begin
            data_valid <= 1'b0;
            double_read <= 1'b0;
        end else begin
            data_valid <= new_request & ls_inputs.load;
            double_read <= new_request & ls_inputs.load & is_double;
        end
    end

    // Undo the swap for doubles.
    // Word reads pass the raw row to the formatter.
    assign sub_unit_data = double_read ? {mem_rdata[31:0], mem_rdata[63:32]} : mem_rdata;

endmodule

/* hdl/ls_request_decode.sv */
/*
 * Request decoder: operation classification, byte enables
 * and lane-aligned store data.
 */

`timescale 1ns/10ps

module ls_request_decode (
    input  ls_local_pkg::ls_request_t                request,
    output ls_local_pkg::data_access_shared_inputs_t ls_inputs
);

    import ls_local_pkg::*;

    logic is_byte;
    logic is_half;
    logic [3:0] byte_be;
    logic [3:0] half_be;

    // Access size from the operation.
    // Anything not byte or half is a full word (or double).
    always_comb begin
        is_byte = 1'b0;
        is_half = 1'b0;
        case (request.op)
            LS_LB, LS_LBU, LS_SB: is_byte = 1'b1;
            LS_LH, LS_LHU, LS_SH: is_half = 1'b1;
            default: ;
        endcase
    end

    // Lane enables within the word.
    assign byte_be = 4'b0001 << request.addr[1:0];
    assign half_be = request.addr[1] ? 4'b1100 : 4'b0011;

    always_comb begin
        ls_inputs = '0;
        ls_inputs.addr = request.addr;

        // Load, store and float class.
        case (request.op)
            LS_LB, LS_LH, LS_LW, LS_LBU, LS_LHU: begin
                ls_inputs.load = 1'b1;
            end
            LS_SB, LS_SH, LS_SW: begin
                ls_inputs.we = 1'b1;
            end
            LS_FLW: begin
                ls_inputs.load = 1'b1;
                ls_inputs.is_float = 1'b1;
                ls_inputs.is_single = 1'b1;
            end
            LS_FSW: begin
                ls_inputs.we = 1'b1;
                ls_inputs.is_float = 1'b1;
                ls_inputs.is_single = 1'b1;
            end
            LS_FLD: begin
                ls_inputs.load = 1'b1;
                ls_inputs.is_float = 1'b1;
            end
            LS_FSD: begin
                ls_inputs.we = 1'b1;
                ls_inputs.is_float = 1'b1;
            end
            default: ;
        endcase

        // Byte enables and replicated integer store data.
        if (is_byte) begin
            ls_inputs.be = byte_be;
            ls_inputs.data_in = {4{request.data[7:0]}};
        end else if (is_half) begin
            ls_inputs.be = half_be;
            ls_inputs.data_in = {2{request.data[15:0]}};
        end else begin
            ls_inputs.be = 4'b1111;
            ls_inputs.data_in = request.data;
        end

        // Loads have no store data.
        // The operation code rides in data_in for the formatter.
        if (ls_inputs.load)
            ls_inputs.data_in = {28'b0, request.op};

        // Single goes in the low 32 bits; double uses all of it.
        if (ls_inputs.is_single)
            ls_inputs.fp_data_in = {32'b0, request.fp_data[31:0]};
        else
            ls_inputs.fp_data_in = request.fp_data;
    end

endmodule

/* hdl/ls_local_pkg.sv */
/*
 * Operation enum and packed access structs shared by the
 * load/store path and its testbench.
 */

`include "ls_local_defs.svh"

package ls_local_pkg;

    // Memory operations, as decoded upstream.
    typedef enum logic [3:0] {
        LS_LB  = 4'd0,
        LS_LH  = 4'd1,
        LS_LW  = 4'd2,
        LS_LBU = 4'd3,
        LS_LHU = 4'd4,
        LS_SB  = 4'd5,
        LS_SH  = 4'd6,
        LS_SW  = 4'd7,
        LS_FLW = 4'd8,
        LS_FSW = 4'd9,
        LS_FLD = 4'd10,
        LS_FSD = 4'd11
    } ls_op_e;

    // Incoming request.
    typedef struct packed {
        ls_op_e              op;
        logic [31:0]         addr;
        logic [31:0]         data;
        logic [`LS_FLEN-1:0] fp_data;
    } ls_request_t;

    // Access signals as the sub-unit sees them.
    typedef struct packed {
        logic [31:0]         addr;
        logic                load;
        logic                we;
        logic [3:0]          be;       // Byte enables within one word.
        logic                is_float;
        logic                is_single;
        logic [31:0]         data_in;  // Already lane-aligned.
        logic [`LS_FLEN-1:0] fp_data_in;
    } data_access_shared_inputs_t;

    // Write strobes.
    // Word writes the half picked by word_sel; both writes the whole row.
    typedef struct packed {
        logic both;
        logic word;
    } mem_we_t;

    // Master-to-RAM bundle.
    typedef struct packed {
        logic [`LS_MEM_DEPTH_LOG2-1:0] addr;
        logic                          en;
        mem_we_t                       we;
        logic                          word_sel;
        logic [3:0]                    be;
        logic [`LS_FLEN-1:0]           data_in;
    } local_mem_port_t;

    // Pending load attributes.
    typedef struct packed {
        ls_op_e     op;
        logic [2:0] offset;
    } load_info_t;

endpackage

/* include/ls_local_defs.svh */
/*
 * Size macros for the local data memory path.
 */

`ifndef LS_LOCAL_DEFS_SVH
`define LS_LOCAL_DEFS_SVH

// Log2 of the number of 64-bit RAM rows.
`define LS_MEM_DEPTH_LOG2 9

// Floating-point register width.
// The RAM row and load result are this wide as well.
`define LS_FLEN 64

`endif
